//--- src/lsu_pkg.sv
package lsu_pkg;

   localparam int ADDR_W = 8;
   localparam int DATA_W = 8;
   localparam int REG_W  = 4;
   localparam int INST_W = 16;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [REG_W-1:0]  reg_t;

   // load view of the instruction word.
   typedef struct packed {
      logic                           is_store;
      logic [INST_W-REG_W-ADDR_W-2:0] reserved;
      reg_t                           rd;
      logic [ADDR_W-1:0]              offset;   // added to the base and wraps at 256.
   } ld_fmt_t;

   // store view of the same word.
   typedef struct packed {
      logic                    is_store;
      logic [INST_W-DATA_W-2:0] reserved;
      data_t                   data;
   } st_fmt_t;

   // is_store is the top bit in both views, so either one can be used to decode.
   typedef union packed {
      ld_fmt_t ld_fmt;
      st_fmt_t st_fmt;
   } mem_inst_u;

endpackage

//--- src/lsu_disp_pick.sv
module lsu_disp_pick #(
   parameter int DISP_SIZE = 4,
   parameter int PICK_NUM  = 0
) (
   input  logic [DISP_SIZE-1:0] i_valid,
   input  lsu_pkg::addr_t       i_addr [DISP_SIZE],
   input  lsu_pkg::mem_inst_u   i_inst [DISP_SIZE],
   output logic                 o_valid,
   output lsu_pkg::addr_t       o_addr,
   output lsu_pkg::mem_inst_u   o_inst
);

   // walk the group from slot 0 and take the slot whose rank among the
   // valid ones equals PICK_NUM.
   always_comb begin
      int rank;
      rank    = 0;
      o_valid = 1'b0;
      o_addr  = '0;
      o_inst  = '0;
      for (int i = 0; i < DISP_SIZE; i++) begin
         if (i_valid[i]) begin
            if (rank == PICK_NUM) begin
               o_valid = 1'b1;
               o_addr  = i_addr[i];
               o_inst  = i_inst[i];
            end
            rank = rank + 1;   // only valid slots count toward the rank.
         end
      end
   end

endmodule

//--- src/lsu_sched_queue.sv
module lsu_sched_queue #(
   parameter int Q_SIZE = 8
) (
   input  logic               i_clk,
   input  logic               i_rst,

   input  logic               i_wr0_valid,
   input  lsu_pkg::addr_t     i_wr0_addr,
   input  lsu_pkg::mem_inst_u i_wr0_inst,

   input  logic               i_wr1_valid,
   input  lsu_pkg::addr_t     i_wr1_addr,
   input  lsu_pkg::mem_inst_u i_wr1_inst,

   output logic               o_ready,

   output logic               o_iss_valid,
   output lsu_pkg::addr_t     o_iss_addr,
   output lsu_pkg::mem_inst_u o_iss_inst
);

   import lsu_pkg::*;

   localparam int PTR_W = (Q_SIZE > 2) ? $clog2(Q_SIZE) : 1;
   localparam int CNT_W = $clog2(Q_SIZE + 1);

   addr_t     addr_q [Q_SIZE];
   mem_inst_u inst_q [Q_SIZE];

   logic [PTR_W-1:0] head;
   logic [PTR_W-1:0] tail;
   logic [CNT_W-1:0] count;

   logic             wr0_en;
   logic             wr1_en;
   logic [PTR_W-1:0] wr1_ptr;
   logic [1:0]       n_wr;
   logic             pop;

   // the pointer wraps at Q_SIZE, which need not be a power of two.
   function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr, input int n);
      int sum;
      sum = int'(ptr) + n;
      if (sum >= Q_SIZE) begin
         sum = sum - Q_SIZE;
      end
      return sum[PTR_W-1:0];
   endfunction

   assign o_ready = (count <= CNT_W'(Q_SIZE - 2));   // room for a full pair.

   assign wr0_en  = i_wr0_valid & o_ready;
   assign wr1_en  = i_wr1_valid & o_ready;
   assign wr1_ptr = wr0_en ? ptr_add(tail, 1) : tail;   // port 0 is the older one.
   assign n_wr    = {1'b0, wr0_en} + {1'b0, wr1_en};

   assign o_iss_valid = (count != '0);
   assign o_iss_addr  = addr_q[head];
   assign o_iss_inst  = inst_q[head];
   assign pop         = o_iss_valid;   // the pipe never stalls.

   always_ff @(posedge i_clk) begin
      if (wr0_en) begin
         addr_q[tail] <= i_wr0_addr;
         inst_q[tail] <= i_wr0_inst;
      end
      if (wr1_en) begin
         addr_q[wr1_ptr] <= i_wr1_addr;
         inst_q[wr1_ptr] <= i_wr1_inst;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         if (pop) begin
            head <= ptr_add(head, 1);
         end
         tail  <= ptr_add(tail, int'(n_wr));
         count <= count + CNT_W'(n_wr) - CNT_W'(pop);
      end
   end

endmodule

//--- src/lsu_pipe.sv
module lsu_pipe (
   input  logic               i_clk,
   input  logic               i_rst,

   input  logic               i_iss_valid,
   input  lsu_pkg::addr_t     i_iss_addr,
   input  lsu_pkg::mem_inst_u i_iss_inst,

   output logic               o_wr_valid,
   output lsu_pkg::reg_t      o_wr_rd,
   output lsu_pkg::data_t     o_wr_data,

   output logic               o_done
);

   import lsu_pkg::*;

   localparam int MEM_DEPTH = 2 ** ADDR_W;

   data_t mem [MEM_DEPTH];

   logic      ex0_valid;
   addr_t     ex0_addr;
   mem_inst_u ex0_inst;

   logic      ex1_valid;
   addr_t     ex1_addr;
   mem_inst_u ex1_inst;
   logic      w_ex1_is_store;
   addr_t     w_ex1_eff_addr;

   logic      ex2_valid;
   logic      ex2_is_store;
   addr_t     ex2_addr;
   reg_t      ex2_rd;
   data_t     ex2_data;
   logic      w_ex2_fwd_hit;
   data_t     w_ex2_ld_data;

   logic      ex3_valid;
   logic      ex3_is_store;
   addr_t     ex3_addr;
   reg_t      ex3_rd;
   data_t     ex3_data;

   // ex1 decodes the word and forms the effective address.
   assign w_ex1_is_store = ex1_inst.st_fmt.is_store;
   assign w_ex1_eff_addr = w_ex1_is_store ? ex1_addr :
                           ex1_addr + ex1_inst.ld_fmt.offset;   // wraps at 256.

   // a store in ex3 has not reached memory yet, so a matching load takes its data.
   assign w_ex2_fwd_hit = ex3_valid & ex3_is_store & (ex3_addr == ex2_addr);
   assign w_ex2_ld_data = w_ex2_fwd_hit ? ex3_data : mem[ex2_addr];

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         ex0_valid <= 1'b0;
         ex1_valid <= 1'b0;
         ex2_valid <= 1'b0;
         ex3_valid <= 1'b0;
      end else begin
         ex0_valid <= i_iss_valid;
         ex1_valid <= ex0_valid;
         ex2_valid <= ex1_valid;
         ex3_valid <= ex2_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      ex0_addr <= i_iss_addr;
      ex0_inst <= i_iss_inst;

      ex1_addr <= ex0_addr;
      ex1_inst <= ex0_inst;

      ex2_is_store <= w_ex1_is_store;
      ex2_addr     <= w_ex1_eff_addr;
      ex2_rd       <= ex1_inst.ld_fmt.rd;
      ex2_data     <= ex1_inst.st_fmt.data;   // meaningful for stores only.

      ex3_is_store <= ex2_is_store;
      ex3_addr     <= ex2_addr;
      ex3_rd       <= ex2_rd;
      ex3_data     <= ex2_is_store ? ex2_data : w_ex2_ld_data;
   end

   // stores commit to memory at the end of ex3.
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (ex3_valid && ex3_is_store) begin
         mem[ex3_addr] <= ex3_data;
      end
   end

   assign o_wr_valid = ex3_valid & ~ex3_is_store;
   assign o_wr_rd    = ex3_rd;
   assign o_wr_data  = ex3_data;
   assign o_done     = ex3_valid;   // one pulse per instruction.

endmodule

//--- src/lsu_top.sv
module lsu_top #(
   parameter int DISP_SIZE = 4,
   parameter int Q_SIZE    = 8
) (
   input  logic                 i_clk,
   input  logic                 i_rst,

   input  logic [DISP_SIZE-1:0] i_disp_valid,
   input  lsu_pkg::addr_t       i_disp_addr [DISP_SIZE],
   input  lsu_pkg::mem_inst_u   i_disp_inst [DISP_SIZE],
   output logic                 o_disp_ready,

   output logic                 o_wr_valid,
   output lsu_pkg::reg_t        o_wr_rd,
   output lsu_pkg::data_t       o_wr_data,

   output logic                 o_done
);

   import lsu_pkg::*;

   logic      pick0_valid;
   addr_t     pick0_addr;
   mem_inst_u pick0_inst;

   logic      pick1_valid;
   addr_t     pick1_addr;
   mem_inst_u pick1_inst;

   logic      iss_valid;
   addr_t     iss_addr;
   mem_inst_u iss_inst;

   // the first picker takes the oldest valid slot and feeds write port 0.
   lsu_disp_pick #(
      .DISP_SIZE (DISP_SIZE),
      .PICK_NUM  (0)
   ) u_pick0 (
      .i_valid (i_disp_valid),
      .i_addr  (i_disp_addr),
      .i_inst  (i_disp_inst),
      .o_valid (pick0_valid),
      .o_addr  (pick0_addr),
      .o_inst  (pick0_inst)
   );

   lsu_disp_pick #(
      .DISP_SIZE (DISP_SIZE),
      .PICK_NUM  (1)
   ) u_pick1 (
      .i_valid (i_disp_valid),
      .i_addr  (i_disp_addr),
      .i_inst  (i_disp_inst),
      .o_valid (pick1_valid),
      .o_addr  (pick1_addr),
      .o_inst  (pick1_inst)
   );

   lsu_sched_queue #(
      .Q_SIZE (Q_SIZE)
   ) u_sched_queue (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_wr0_valid (pick0_valid),
      .i_wr0_addr  (pick0_addr),
      .i_wr0_inst  (pick0_inst),
      .i_wr1_valid (pick1_valid),
      .i_wr1_addr  (pick1_addr),
      .i_wr1_inst  (pick1_inst),
      .o_ready     (o_disp_ready),
      .o_iss_valid (iss_valid),
      .o_iss_addr  (iss_addr),
      .o_iss_inst  (iss_inst)
   );

   lsu_pipe u_lsu_pipe (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_iss_valid (iss_valid),
      .i_iss_addr  (iss_addr),
      .i_iss_inst  (iss_inst),
      .o_wr_valid  (o_wr_valid),
      .o_wr_rd     (o_wr_rd),
      .o_wr_data   (o_wr_data),
      .o_done      (o_done)
   );

endmodule

//--- tests/tb_clkgen.sv
module tb_clkgen #(
   parameter int PERIOD     = 20,
   parameter int RST_CYCLES = 4
) (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD / 2) o_clk = ~o_clk;
   end

   // reset covers RST_CYCLES rising edges and drops on a falling edge.
   initial begin
      o_rst = 1'b1;
      repeat (RST_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst = 1'b0;
   end

endmodule

//--- tests/tb_lsu_top.sv
module tb_lsu_top;

   import lsu_pkg::*;

   localparam int DISP_SIZE = 4;
   localparam int Q_SIZE    = 8;

   logic                 clk;
   logic                 rst;
   logic [DISP_SIZE-1:0] disp_valid;
   addr_t                disp_addr [DISP_SIZE];
   mem_inst_u            disp_inst [DISP_SIZE];
   logic                 o_disp_ready;
   logic                 o_wr_valid;
   reg_t                 o_wr_rd;
   data_t                o_wr_data;
   logic                 o_done;

   data_t model_mem [256];   // memory as seen in program order.
   reg_t  exp_rd [$];
   data_t exp_data [$];
   int    outstanding;
   int    q_count;           // expected queue occupancy.
   int    pending_wr;
   int    groups;
   int    cycles;
   int    seed;

   tb_clkgen u_clkgen (.o_clk(clk), .o_rst(rst));

   lsu_top #(.DISP_SIZE(DISP_SIZE), .Q_SIZE(Q_SIZE)) dut0 (
      .i_clk(clk), .i_rst(rst),
      .i_disp_valid(disp_valid), .i_disp_addr(disp_addr), .i_disp_inst(disp_inst),
      .o_disp_ready(o_disp_ready),
      .o_wr_valid(o_wr_valid), .o_wr_rd(o_wr_rd), .o_wr_data(o_wr_data),
      .o_done(o_done)
   );

   task automatic report_fail();
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_wr(input reg_t exp_r, input data_t exp_d,
                           input reg_t got_r, input data_t got_d);
      if (got_r !== exp_r || got_d !== exp_d) begin
         $display("Error at time %0t: register write rd=%0d data=%02h, expected rd=%0d data=%02h",
                  $time, got_r, got_d, exp_r, exp_d);
         report_fail();
      end
   endtask

   task automatic check_ready(input logic exp_lvl, input logic got_lvl);
      if (got_lvl !== exp_lvl) begin
         $display("Error at time %0t: o_disp_ready is %b, expected %b", $time, got_lvl, exp_lvl);
         report_fail();
      end
   endtask

   // waits for the falling edge and checks everything the DUT shows.
   task automatic tick();
      @(negedge clk);
      cycles = cycles + 1;
      if (cycles > 40 * groups + 200) begin
         $display("Timeout after %0d cycles, the DUT stopped completing instructions.", cycles);
         report_fail();
      end
      q_count    = q_count + pending_wr - ((q_count != 0) ? 1 : 0);
      pending_wr = 0;
      check_ready(q_count <= Q_SIZE - 2, o_disp_ready);   // two free entries needed.
      if (o_done) begin
         if (outstanding == 0) begin
            $display("Error at time %0t: o_done with no instruction in flight", $time);
            report_fail();
         end
         outstanding = outstanding - 1;
      end
      if (o_wr_valid) begin
         if (exp_rd.size() == 0) begin
            $display("Error at time %0t: register write with no load pending", $time);
            report_fail();
         end
         check_wr(exp_rd.pop_front(), exp_data.pop_front(), o_wr_rd, o_wr_data);
      end
   endtask

   function automatic mem_inst_u make_load(input reg_t rd, input logic [7:0] off);
      mem_inst_u w;
      w                 = '0;
      w.ld_fmt.is_store = 1'b0;
      w.ld_fmt.rd       = rd;
      w.ld_fmt.offset   = off;
      return w;
   endfunction

   function automatic mem_inst_u make_store(input data_t d);
      mem_inst_u w;
      w                 = '0;
      w.st_fmt.is_store = 1'b1;
      w.st_fmt.data     = d;
      return w;
   endfunction

   task automatic set_slot(input int k, input addr_t a, input mem_inst_u w);
      disp_addr[k] = a;
      disp_inst[k] = w;
   endtask

   task automatic apply_model(input int k);
      addr_t ea;
      if (disp_inst[k].st_fmt.is_store) begin
         model_mem[disp_addr[k]] = disp_inst[k].st_fmt.data;
      end else begin
         ea = disp_addr[k] + disp_inst[k].ld_fmt.offset;   // wraps at 256.
         exp_rd.push_back(disp_inst[k].ld_fmt.rd);
         exp_data.push_back(model_mem[ea]);
      end
   endtask

   // only the first two valid slots of a group are executed.
   task automatic send_group(input logic [DISP_SIZE-1:0] v);
      int picked;
      picked = 0;
      while (o_disp_ready !== 1'b1) tick();
      disp_valid = v;
      for (int k = 0; k < DISP_SIZE; k++) begin
         if (v[k] && picked < 2) begin
            apply_model(k);
            picked = picked + 1;
         end
      end
      outstanding = outstanding + picked;
      pending_wr  = picked;
      groups      = groups + 1;
      tick();
      disp_valid = '0;
   endtask

   task automatic wait_idle();
      while (outstanding != 0 || exp_rd.size() != 0) tick();
      repeat (6) tick();   // room for stray pulses to show up.
   endtask

   task automatic test_reset_state();
      check_ready(1'b1, o_disp_ready);
      repeat (10) tick();
   endtask

   task automatic test_store_load_fwd();
      int r;
      r = $random(seed);
      // nonzero so the result differs from the cleared memory.
      set_slot(0, 8'h40, make_store(r[7:0] | 8'h80));
      set_slot(1, 8'h40, make_load(4'd3, 8'h00));
      send_group(4'b0011);
      wait_idle();
   endtask

   task automatic test_addr_wrap();
      set_slot(0, 8'h10, make_store(8'h5c));
      set_slot(1, 8'h00, make_store(8'hee));
      set_slot(2, 8'hf8, make_load(4'd1, 8'h18));   // 0xf8 + 0x18 wraps to 0x10.
      send_group(4'b0101);
      set_slot(0, 8'hc0, make_load(4'd2, 8'h50));
      set_slot(1, 8'hff, make_load(4'd4, 8'h02));   // lands on 0x01, which was never written.
      send_group(4'b0011);
      wait_idle();
   endtask

   task automatic test_slot_pick();
      set_slot(0, 8'h30, make_store(8'h11));
      set_slot(1, 8'h30, make_store(8'h22));
      set_slot(2, 8'h30, make_store(8'h33));
      set_slot(3, 8'h30, make_load(4'd2, 8'h00));
      send_group(4'b1010);
      set_slot(0, 8'h50, make_store(8'h7e));
      set_slot(1, 8'h50, make_load(4'd5, 8'h00));
      set_slot(2, 8'h70, make_store(8'h99));   // beyond the second valid slot.
      set_slot(3, 8'h71, make_store(8'h98));
      send_group(4'b1111);
      set_slot(0, 8'h70, make_load(4'd6, 8'h00));
      set_slot(1, 8'h60, make_load(4'd7, 8'h11));
      send_group(4'b0011);
      wait_idle();
   endtask

   task automatic test_burst();
      int   r;
      logic went_low;
      went_low = 1'b0;
      while (!(went_low && o_disp_ready)) begin
         if (o_disp_ready) begin
            for (int k = 0; k < 2; k++) begin
               r = $random(seed);
               if (r[4]) begin
                  set_slot(k, {6'b001000, r[1:0]}, make_store(r[15:8]));
               end else begin
                  set_slot(k, 8'h20, make_load(r[19:16], {6'd0, r[3:2]}));
               end
            end
            send_group(4'b0011);
         end else begin
            went_low = 1'b1;
            tick();
         end
      end
      wait_idle();
      check_ready(1'b1, o_disp_ready);
   endtask

   initial begin
      disp_valid  = '0;
      for (int k = 0; k < DISP_SIZE; k++) begin
         disp_addr[k] = '0;
         disp_inst[k] = '0;
      end
      for (int i = 0; i < 256; i++) begin
         model_mem[i] = '0;
      end
      outstanding = 0;
      q_count     = 0;
      pending_wr  = 0;
      groups      = 0;
      cycles      = 0;
      seed        = 32'h3b40_6396;
      while (rst !== 1'b0) @(negedge clk);
      test_reset_state();
      test_store_load_fwd();
      test_addr_wrap();
      test_slot_pick();
      test_burst();
      $display("test passed");
      $finish;
   end

endmodule

//--- compile.f
src/lsu_pkg.sv
src/lsu_disp_pick.sv
src/lsu_sched_queue.sv
src/lsu_pipe.sv
src/lsu_top.sv
tests/tb_clkgen.sv
tests/tb_lsu_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_lsu_top
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := test passed

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
